//--- include/dtm_cfg.svh
// JTAG debug transport configuration
// identification value, TAP instruction length and DMI sizing

`ifndef DTM_CFG_SVH
`define DTM_CFG_SVH

// --------------------
// TAP
// --------------------
// jedec style idcode, lsb must stay set
`define DTM_IDCODE 32'h1000_0DB3
`define DTM_IR_LEN 5

// --------------------
// DMI
// --------------------
`define DMI_ABITS 7
// request buffer entries between DTM and register file
`define DMI_FIFO_DEPTH 2
// words in the debug register file
`define DM_NUM_REGS 8

`endif

//--- rtl/dtm_pkg.sv
// DMI transport types
// request and response words, DTMCS layout and the DMI scan register views

`include "dtm_cfg.svh"

package dtm_pkg;

  typedef enum logic [1:0] {
    op_nop   = 2'd0,
    op_read  = 2'd1,
    op_write = 2'd2
  } dmi_op_e;

  // same encoding serves as the sticky dmistat value
  typedef enum logic [1:0] {
    resp_success = 2'd0,
    resp_error   = 2'd2,
    resp_busy    = 2'd3
  } dmi_resp_e;

  typedef struct packed {
    logic [`DMI_ABITS-1:0] addr;
    logic [31:0]           data;
    dmi_op_e               op;
  } dmi_req_t;

  typedef struct packed {
    logic [31:0] data;
    dmi_resp_e   resp;
  } dmi_resp_t;

  // status view of the DMI register as captured for shift-out
  typedef struct packed {
    logic [`DMI_ABITS-1:0] addr;
    logic [31:0]           data;
    dmi_resp_e             status;
  } dmi_status_t;

  // one 41 bit scan register, low two bits are op on update, status on capture
  typedef union packed {
    dmi_req_t    req;
    dmi_status_t status;
  } dmi_dr_u;

  typedef struct packed {
    logic [13:0] zero1;
    logic        dmihardreset;
    logic        dmireset;
    logic        zero0;
    logic [2:0]  idle;
    logic [1:0]  dmistat;
    logic [5:0]  abits;
    logic [3:0]  version;
  } dtmcs_t;

endpackage

//--- rtl/jtag_tap.sv
// JTAG TAP controller
// sixteen state TAP FSM, instruction register, IDCODE and BYPASS registers,
// data register strobes toward the DTM and falling edge TDO output

`timescale 1ns/1ps
`include "dtm_cfg.svh"

module jtag_tap (
  input  logic tck_i,
  input  logic trst_ni,
  input  logic tms_i,
  input  logic td_i,
  output logic td_o,
  output logic tdo_oe_o,
  output logic capture_o,
  output logic shift_o,
  output logic update_o,
  output logic dmi_clear_o,
  output logic dtmcs_select_o,
  output logic dmi_select_o,
  input  logic dtmcs_tdo_i,
  input  logic dmi_tdo_i
);

  localparam logic [`DTM_IR_LEN-1:0] ir_idcode = `DTM_IR_LEN'h01;
  localparam logic [`DTM_IR_LEN-1:0] ir_dtmcs  = `DTM_IR_LEN'h10;
  localparam logic [`DTM_IR_LEN-1:0] ir_dmi    = `DTM_IR_LEN'h11;

  typedef enum logic [3:0] {
    test_logic_reset, run_test_idle,
    select_dr_scan, capture_dr, shift_dr, exit1_dr, pause_dr, exit2_dr, update_dr,
    select_ir_scan, capture_ir, shift_ir, exit1_ir, pause_ir, exit2_ir, update_ir
  } tap_state_e;

  tap_state_e state_d, state_q;

  logic [`DTM_IR_LEN-1:0] ir_shift_q, ir_q;
  logic [31:0]            idcode_q;
  logic                   bypass_q;
  logic                   idcode_select;
  logic                   tdo_mux;

  // --------------------
  // TAP state machine
  // --------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      test_logic_reset: state_d = tms_i ? test_logic_reset : run_test_idle;
      run_test_idle:    state_d = tms_i ? select_dr_scan : run_test_idle;
      select_dr_scan:   state_d = tms_i ? select_ir_scan : capture_dr;
      capture_dr:       state_d = tms_i ? exit1_dr : shift_dr;
      shift_dr:         state_d = tms_i ? exit1_dr : shift_dr;
      exit1_dr:         state_d = tms_i ? update_dr : pause_dr;
      pause_dr:         state_d = tms_i ? exit2_dr : pause_dr;
      exit2_dr:         state_d = tms_i ? update_dr : shift_dr;
      update_dr:        state_d = tms_i ? select_dr_scan : run_test_idle;
      select_ir_scan:   state_d = tms_i ? test_logic_reset : capture_ir;
      capture_ir:       state_d = tms_i ? exit1_ir : shift_ir;
      shift_ir:         state_d = tms_i ? exit1_ir : shift_ir;
      exit1_ir:         state_d = tms_i ? update_ir : pause_ir;
      pause_ir:         state_d = tms_i ? exit2_ir : pause_ir;
      exit2_ir:         state_d = tms_i ? update_ir : shift_ir;
      update_ir:        state_d = tms_i ? select_dr_scan : run_test_idle;
      default:          state_d = test_logic_reset;
    endcase
  end

  always_ff @(posedge tck_i or negedge trst_ni) begin
    if (!trst_ni) begin
      state_q <= test_logic_reset;
    end else begin
      state_q <= state_d;
    end
  end

  // --------------------
  // instruction register
  // --------------------
  always_ff @(posedge tck_i or negedge trst_ni) begin
    if (!trst_ni) begin
      ir_shift_q <= '0;
      ir_q       <= ir_idcode;
    end else begin
      // capture pattern ends in 01 as required by the standard
      if (state_q == capture_ir) begin
        ir_shift_q <= `DTM_IR_LEN'(1);
      end else if (state_q == shift_ir) begin
        ir_shift_q <= {td_i, ir_shift_q[`DTM_IR_LEN-1:1]};
      end
      if (state_q == test_logic_reset) begin
        ir_q <= ir_idcode;
      end else if (state_q == update_ir) begin
        ir_q <= ir_shift_q;
      end
    end
  end

  assign idcode_select  = (ir_q == ir_idcode);
  assign dtmcs_select_o = (ir_q == ir_dtmcs);
  assign dmi_select_o   = (ir_q == ir_dmi);

  // --------------------
  // IDCODE and BYPASS
  // --------------------
  always_ff @(posedge tck_i or negedge trst_ni) begin
    if (!trst_ni) begin
      idcode_q <= `DTM_IDCODE;
      bypass_q <= 1'b0;
    end else begin
      if (state_q == capture_dr) begin
        idcode_q <= `DTM_IDCODE;
        bypass_q <= 1'b0;
      end else if (state_q == shift_dr) begin
        idcode_q <= {td_i, idcode_q[31:1]};
        bypass_q <= td_i;
      end
    end
  end

  // strobes for the DTM registers
  assign capture_o   = (state_q == capture_dr);
  assign shift_o     = (state_q == shift_dr);
  assign update_o    = (state_q == update_dr);
  assign dmi_clear_o = (state_q == test_logic_reset);

  // --------------------
  // TDO
  // --------------------
  always_comb begin
    if (state_q == shift_ir) begin
      tdo_mux = ir_shift_q[0];
    end else if (idcode_select) begin
      tdo_mux = idcode_q[0];
    end else if (dtmcs_select_o) begin
      tdo_mux = dtmcs_tdo_i;
    end else if (dmi_select_o) begin
      tdo_mux = dmi_tdo_i;
    end else begin
      // every unknown code falls back to bypass
      tdo_mux = bypass_q;
    end
  end

  // launch on falling edge so the host samples a stable bit on the rising edge
  always_ff @(negedge tck_i or negedge trst_ni) begin
    if (!trst_ni) begin
      td_o <= 1'b0;
    end else begin
      td_o <= tdo_mux;
    end
  end

  assign tdo_oe_o = (state_q == shift_ir) || (state_q == shift_dr);

endmodule

//--- rtl/dmi_dtm.sv
// DMI debug transport module
// holds DTMCS and the DMI scan register, turns each DMI update into a
// request and keeps the sticky error reported through dmistat

`timescale 1ns/1ps
`include "dtm_cfg.svh"

module dmi_dtm (
  input  logic                tck_i,
  input  logic                trst_ni,
  input  logic                td_i,
  input  logic                capture_i,
  input  logic                shift_i,
  input  logic                update_i,
  input  logic                dmi_clear_i,
  input  logic                dtmcs_select_i,
  input  logic                dmi_select_i,
  output logic                dtmcs_tdo_o,
  output logic                dmi_tdo_o,
  output dtm_pkg::dmi_req_t   req_o,
  output logic                req_valid_o,
  input  logic                req_ready_i,
  input  dtm_pkg::dmi_resp_t  resp_i,
  input  logic                resp_valid_i,
  output logic                fifo_clear_o
);

  typedef enum logic [1:0] {st_idle, st_req, st_wait} state_e;

  state_e              state_d, state_q;
  dtm_pkg::dtmcs_t     dtmcs_d, dtmcs_q;
  dtm_pkg::dmi_dr_u    dr_d, dr_q;
  dtm_pkg::dmi_req_t   req_d, req_q;
  dtm_pkg::dmi_resp_e  error_d, error_q;
  logic                dmi_clear;
  logic                busy_now;
  logic                resp_busy;
  logic                op_failed;

  // test logic reset or a dmihardreset write wipes the whole DMI path
  assign dmi_clear    = dmi_clear_i || (dtmcs_select_i && update_i && dtmcs_q.dmihardreset);
  assign fifo_clear_o = dmi_clear;

  // DMI scan started while a request is still in flight
  assign busy_now = dmi_select_i && (capture_i || update_i) && (state_q != st_idle);

  assign req_o       = req_q;
  assign req_valid_o = (state_q == st_req);
  assign dtmcs_tdo_o = dtmcs_q[0];
  assign dmi_tdo_o   = dr_q[0];

  // --------------------
  // DTMCS
  // --------------------
  always_comb begin
    dtmcs_d = dtmcs_q;
    if (dtmcs_select_i && capture_i) begin
      dtmcs_d         = '0;
      dtmcs_d.idle    = 3'd1;
      dtmcs_d.dmistat = error_q;
      dtmcs_d.abits   = 6'(`DMI_ABITS);
      dtmcs_d.version = 4'd1;
    end else if (dtmcs_select_i && shift_i) begin
      dtmcs_d = {td_i, dtmcs_q[31:1]};
    end
  end

  // --------------------
  // request FSM
  // --------------------
  always_comb begin
    state_d   = state_q;
    req_d     = req_q;
    error_d   = error_q;
    resp_busy = 1'b0;
    op_failed = 1'b0;
    if (dmi_clear) begin
      state_d = st_idle;
      req_d   = '0;
      error_d = dtm_pkg::resp_success;
    end else begin
      case (state_q)
        st_idle: begin
          // nop scans and scans under a sticky error are dropped
          if (dmi_select_i && update_i && (error_q == dtm_pkg::resp_success) &&
              (dr_q.req.op inside {dtm_pkg::op_read, dtm_pkg::op_write})) begin
            req_d   = dr_q.req;
            state_d = st_req;
          end
        end
        st_req: begin
          if (req_ready_i) begin
            state_d = st_wait;
          end
        end
        st_wait: begin
          if (resp_valid_i) begin
            state_d = st_idle;
            case (resp_i.resp)
              dtm_pkg::resp_success: begin
                if (req_q.op == dtm_pkg::op_read) begin
                  req_d.data = resp_i.data;
                end
              end
              dtm_pkg::resp_error: begin
                req_d.data = 32'hdead_beef;
                op_failed  = 1'b1;
              end
              default: resp_busy = 1'b1;
            endcase
          end
        end
        default: state_d = st_idle;
      endcase
      // first error wins until dmireset
      if ((busy_now || resp_busy) && (error_q == dtm_pkg::resp_success)) begin
        error_d = dtm_pkg::resp_busy;
      end
      if (op_failed && (error_q == dtm_pkg::resp_success)) begin
        error_d = dtm_pkg::resp_error;
      end
      if (dtmcs_select_i && update_i && dtmcs_q.dmireset) begin
        error_d = dtm_pkg::resp_success;
      end
    end
  end

  // --------------------
  // DMI scan register
  // --------------------
  always_comb begin
    dr_d = dr_q;
    if (dmi_clear) begin
      dr_d = '0;
    end else if (dmi_select_i && capture_i) begin
      dr_d.status.addr   = req_q.addr;
      dr_d.status.data   = req_q.data;
      // a capture that collides with a busy DTM already reports busy
      dr_d.status.status = busy_now ? dtm_pkg::resp_busy : error_q;
    end else if (dmi_select_i && shift_i) begin
      dr_d = {td_i, dr_q[$bits(dr_q)-1:1]};
    end
  end

  always_ff @(posedge tck_i or negedge trst_ni) begin
    if (!trst_ni) begin
      state_q <= st_idle;
      error_q <= dtm_pkg::resp_success;
      dtmcs_q <= '0;
      dr_q    <= '0;
      req_q   <= '0;
    end else begin
      state_q <= state_d;
      error_q <= error_d;
      dtmcs_q <= dtmcs_d;
      dr_q    <= dr_d;
      req_q   <= req_d;
    end
  end

endmodule

//--- rtl/dmi_req_fifo.sv
// DMI request buffer
// small circular FIFO between the DTM and the register file with valid/ready
// on both sides and a synchronous flush

`timescale 1ns/1ps
`include "dtm_cfg.svh"

module dmi_req_fifo (
  input  logic               tck_i,
  input  logic               trst_ni,
  input  logic               clear_i,
  input  logic               push_valid_i,
  output logic               push_ready_o,
  input  dtm_pkg::dmi_req_t  push_req_i,
  output logic               pop_valid_o,
  input  logic               pop_ready_i,
  output dtm_pkg::dmi_req_t  pop_req_o
);

  localparam int unsigned depth = `DMI_FIFO_DEPTH;
  localparam int unsigned ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int unsigned cnt_w = $clog2(depth + 1);

  dtm_pkg::dmi_req_t mem_q [depth];
  logic [ptr_w-1:0]  wr_ptr_q, rd_ptr_q;
  logic [cnt_w-1:0]  count_q;
  logic              push;
  logic              pop;

  assign push_ready_o = (count_q != cnt_w'(depth));
  assign pop_valid_o  = (count_q != '0);
  assign pop_req_o    = mem_q[rd_ptr_q];

  assign push = push_valid_i && push_ready_o;
  assign pop  = pop_valid_o && pop_ready_i;

  // storage, entry is visible at the output right after the push edge
  always_ff @(posedge tck_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_req_i;
    end
  end

  always_ff @(posedge tck_i or negedge trst_ni) begin
    if (!trst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == ptr_w'(depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_w'(depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // simultaneous push and pop leaves occupancy unchanged
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

//--- rtl/dm_regfile.sv
// debug register file
// eight read/write words behind the DMI, one request in flight,
// response valid for the single cycle after the pop

`timescale 1ns/1ps
`include "dtm_cfg.svh"

module dm_regfile (
  input  logic               tck_i,
  input  logic               trst_ni,
  input  logic               req_valid_i,
  output logic               req_ready_o,
  input  dtm_pkg::dmi_req_t  req_i,
  output dtm_pkg::dmi_resp_t resp_o,
  output logic               resp_valid_o
);

  localparam int unsigned idx_w = $clog2(`DM_NUM_REGS);

  logic [31:0]        regs_q [`DM_NUM_REGS];
  dtm_pkg::dmi_resp_t resp_q;
  logic               resp_valid_q;
  logic               accept;
  logic               in_range;
  logic [idx_w-1:0]   idx;

  // one outstanding response at a time
  assign req_ready_o  = !resp_valid_q;
  assign accept       = req_valid_i && req_ready_o;
  assign in_range     = (req_i.addr < `DMI_ABITS'(`DM_NUM_REGS));
  assign idx          = req_i.addr[idx_w-1:0];
  assign resp_o       = resp_q;
  assign resp_valid_o = resp_valid_q;

  always_ff @(posedge tck_i or negedge trst_ni) begin
    if (!trst_ni) begin
      resp_valid_q <= 1'b0;
      for (int i = 0; i < `DM_NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else begin
      resp_valid_q <= accept;
      if (accept && in_range && (req_i.op == dtm_pkg::op_write)) begin
        regs_q[idx] <= req_i.data;
      end
    end
  end

  // --------------------
  // response payload
  // --------------------
  always_ff @(posedge tck_i) begin
    if (accept) begin
      if (!in_range) begin
        // out of range, nothing touched
        resp_q.data <= '0;
        resp_q.resp <= dtm_pkg::resp_error;
      end else if (req_i.op == dtm_pkg::op_read) begin
        resp_q.data <= regs_q[idx];
        resp_q.resp <= dtm_pkg::resp_success;
      end else begin
        // writes answer with zero data
        resp_q.data <= '0;
        resp_q.resp <= dtm_pkg::resp_success;
      end
    end
  end

endmodule

//--- rtl/jtag_dmi_top.sv
// JTAG debug transport top level
// TAP, DTM, request FIFO and debug register file on the JTAG pins

`timescale 1ns/1ps

module jtag_dmi_top (
  input  logic tck_i,
  input  logic trst_ni,
  input  logic tms_i,
  input  logic td_i,
  output logic td_o,
  output logic tdo_oe_o
);

  // TAP to DTM
  logic capture, shift, update, dmi_clear;
  logic dtmcs_select, dmi_select;
  logic dtmcs_tdo, dmi_tdo;

  // DTM to FIFO
  dtm_pkg::dmi_req_t  dtm_req;
  logic               dtm_req_valid, dtm_req_ready, fifo_clear;

  // FIFO to register file and response back
  dtm_pkg::dmi_req_t  rf_req;
  logic               rf_req_valid, rf_req_ready;
  dtm_pkg::dmi_resp_t rf_resp;
  logic               rf_resp_valid;

  jtag_tap u_jtag_tap (
    .tck_i, .trst_ni, .tms_i, .td_i, .td_o, .tdo_oe_o,
    .capture_o (capture), .shift_o (shift), .update_o (update),
    .dmi_clear_o (dmi_clear), .dtmcs_select_o (dtmcs_select), .dmi_select_o (dmi_select),
    .dtmcs_tdo_i (dtmcs_tdo), .dmi_tdo_i (dmi_tdo)
  );

  dmi_dtm u_dmi_dtm (
    .tck_i, .trst_ni, .td_i,
    .capture_i (capture), .shift_i (shift), .update_i (update),
    .dmi_clear_i (dmi_clear), .dtmcs_select_i (dtmcs_select), .dmi_select_i (dmi_select),
    .dtmcs_tdo_o (dtmcs_tdo), .dmi_tdo_o (dmi_tdo),
    .req_o (dtm_req), .req_valid_o (dtm_req_valid), .req_ready_i (dtm_req_ready),
    .resp_i (rf_resp), .resp_valid_i (rf_resp_valid), .fifo_clear_o (fifo_clear)
  );

  dmi_req_fifo u_dmi_req_fifo (
    .tck_i, .trst_ni, .clear_i (fifo_clear),
    .push_valid_i (dtm_req_valid), .push_ready_o (dtm_req_ready), .push_req_i (dtm_req),
    .pop_valid_o (rf_req_valid), .pop_ready_i (rf_req_ready), .pop_req_o (rf_req)
  );

  dm_regfile u_dm_regfile (
    .tck_i, .trst_ni,
    .req_valid_i (rf_req_valid), .req_ready_o (rf_req_ready), .req_i (rf_req),
    .resp_o (rf_resp), .resp_valid_o (rf_resp_valid)
  );

endmodule

//--- tests/tb_jtag_dmi.sv
// JTAG debug transport testbench
// bit-bangs the TAP pins through a stimulus table and checks IDCODE, BYPASS,
// DTMCS, DMI results and the TDO output enable against a shadow model

`timescale 1ns/1ps
`include "dtm_cfg.svh"

module tb_jtag_dmi;

  typedef enum logic [2:0] {
    k_idcode, k_bypass, k_dtmcs_read, k_dtmcs_write,
    k_dmi_write, k_dmi_read, k_dmi_fast, k_tap_reset
  } kind_e;

  typedef struct packed {
    kind_e                 kind;
    logic [`DMI_ABITS-1:0] addr;
    logic [31:0]           data;
    logic [31:0]           exp_val;
  } entry_t;

  localparam int dr_len = $bits(dtm_pkg::dmi_dr_u);
  localparam logic [`DTM_IR_LEN-1:0] ir_dtmcs  = `DTM_IR_LEN'h10;
  localparam logic [`DTM_IR_LEN-1:0] ir_dmi    = `DTM_IR_LEN'h11;
  localparam logic [`DTM_IR_LEN-1:0] ir_bypass = '1;

  logic tck = 1'b0;
  logic trst_ni, tms_i, td_i, td_o, tdo_oe_o;

  entry_t      stim_q[$];
  bit          table_built = 1'b0;
  integer      seed;
  int          err_cnt = 0;
  int          pass_cnt = 0;
  int          fail_cnt = 0;
  bit          entry_ok;
  // tck cycles with tdo_oe_o high since the current scan started
  int          oe_cycles = 0;
  // model of the shadow words, the last request and the sticky error
  logic [31:0] shadow [`DM_NUM_REGS];
  logic [`DMI_ABITS-1:0] last_addr;
  logic [31:0] last_data;
  logic [1:0]  sticky;

  jtag_dmi_top u_jtag_dmi_top (
    .tck_i (tck), .trst_ni, .tms_i, .td_i, .td_o, .tdo_oe_o
  );

  always #4 tck = ~tck;

  // --------------------
  // JTAG pin tasks
  // --------------------
  // one tck cycle with pins set on the falling edge and tdo read after the rising edge
  task automatic tck_step(input logic tms, input logic tdi, output logic tdo);
    @(negedge tck);
    // output enable follows the TAP state, stable away from the rising edge
    if (tdo_oe_o === 1'b1) begin
      oe_cycles++;
    end
    tms_i = tms;
    td_i  = tdi;
    @(posedge tck);
    tdo = td_o;
  endtask

  task automatic run_idle(input int n);
    logic tdo;
    for (int i = 0; i < n; i++) begin
      tck_step(1'b0, 1'b0, tdo);
    end
  endtask

  // --------------------
  // compare tasks
  // --------------------
  task automatic check_idcode(input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL @ %0t: idcode got %h expected %h", $time, got, exp);
      err_cnt++;
      entry_ok = 1'b0;
    end
  endtask

  task automatic check_bypass(input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL @ %0t: bypass got %h expected %h", $time, got, exp);
      err_cnt++;
      entry_ok = 1'b0;
    end
  endtask

  task automatic check_oe(input int got, input int exp);
    if (got != exp) begin
      $display("FAIL @ %0t: tdo_oe_o high for %0d cycles of a scan, expected %0d",
               $time, got, exp);
      err_cnt++;
      entry_ok = 1'b0;
    end
  endtask

  task automatic check_dtmcs(input dtm_pkg::dtmcs_t got, input dtm_pkg::dtmcs_t exp);
    if (got !== exp) begin
      $display("FAIL @ %0t: dtmcs got %h (dmistat %0d) expected %h (dmistat %0d)",
               $time, got, got.dmistat, exp, exp.dmistat);
      err_cnt++;
      entry_ok = 1'b0;
    end
  endtask

  task automatic check_dmi(input dtm_pkg::dmi_dr_u got, input dtm_pkg::dmi_dr_u exp);
    if (got.status !== exp.status) begin
      $display({"FAIL @ %0t: dmi got addr %0d data %h status %0d, ",
                "expected addr %0d data %h status %0d"},
               $time, got.status.addr, got.status.data, got.status.status,
               exp.status.addr, exp.status.data, exp.status.status);
      err_cnt++;
      entry_ok = 1'b0;
    end
  endtask

  // --------------------
  // scan tasks
  // --------------------
  // starts in run-test/idle or update-dr, ends in run-test/idle
  task automatic shift_ir(input logic [`DTM_IR_LEN-1:0] ir);
    logic tdo;
    oe_cycles = 0;
    tck_step(1'b1, 1'b0, tdo);
    tck_step(1'b1, 1'b0, tdo);
    tck_step(1'b0, 1'b0, tdo);
    tck_step(1'b0, 1'b0, tdo);
    for (int i = 0; i < `DTM_IR_LEN; i++) begin
      tck_step(i == `DTM_IR_LEN - 1, ir[i], tdo);
    end
    tck_step(1'b1, 1'b0, tdo);
    tck_step(1'b0, 1'b0, tdo);
    // enable only while in shift-ir
    check_oe(oe_cycles, `DTM_IR_LEN);
  endtask

  // shifts lsb first and stops in update-dr so the next step decides idle or a back to back scan
  task automatic shift_dr(input int len, input logic [63:0] din, output logic [63:0] dout);
    logic tdo;
    dout = '0;
    oe_cycles = 0;
    tck_step(1'b1, 1'b0, tdo);
    tck_step(1'b0, 1'b0, tdo);
    tck_step(1'b0, 1'b0, tdo);
    for (int i = 0; i < len; i++) begin
      tck_step(i == len - 1, din[i], tdo);
      dout[i] = tdo;
    end
    tck_step(1'b1, 1'b0, tdo);
    // enable only while in shift-dr
    check_oe(oe_cycles, len);
  endtask

  task automatic tap_reset();
    logic tdo;
    oe_cycles = 0;
    for (int i = 0; i < 5; i++) begin
      tck_step(1'b1, 1'b0, tdo);
    end
    tck_step(1'b0, 1'b0, tdo);
    check_oe(oe_cycles, 0);
  endtask

  // --------------------
  // entry handlers
  // --------------------
  task automatic dtmcs_access(input entry_t e);
    dtm_pkg::dtmcs_t exp;
    dtm_pkg::dtmcs_t wr;
    logic [63:0]     dout;
    wr = '0;
    if (e.kind == k_dtmcs_write) begin
      wr = e.data;
    end
    exp         = '0;
    exp.idle    = 3'd1;
    exp.dmistat = e.exp_val[1:0];
    exp.abits   = 6'(`DMI_ABITS);
    exp.version = 4'd1;
    shift_ir(ir_dtmcs);
    shift_dr(32, {32'd0, wr}, dout);
    run_idle(1);
    check_dtmcs(dout[31:0], exp);
    if (wr.dmireset || wr.dmihardreset) begin
      sticky = 2'd0;
    end
  endtask

  task automatic dmi_access(input entry_t e);
    dtm_pkg::dmi_dr_u scan_in;
    dtm_pkg::dmi_dr_u exp;
    dtm_pkg::dmi_dr_u got;
    logic [63:0]      din;
    logic [63:0]      dout;
    logic             accepted;
    logic             fast;
    accepted = (sticky == 2'd0);
    fast     = (e.kind == k_dmi_fast);
    scan_in.req.addr = e.addr;
    if (e.kind == k_dmi_write) begin
      scan_in.req.data = e.data;
      scan_in.req.op   = dtm_pkg::op_write;
    end else begin
      scan_in.req.data = 32'd0;
      scan_in.req.op   = dtm_pkg::op_read;
    end
    din = '0;
    din[dr_len-1:0] = scan_in;
    shift_ir(ir_dmi);
    shift_dr(dr_len, din, dout);
    // a fast capture lands while the request is still in flight
    exp = '0;
    if (accepted && fast) begin
      exp.status.addr = e.addr;
      exp.status.data = scan_in.req.data;
    end
    if (accepted) begin
      last_addr = e.addr;
      if (e.addr < `DM_NUM_REGS) begin
        if (e.kind == k_dmi_write) begin
          shadow[e.addr[2:0]] = e.data;
        end
        last_data = shadow[e.addr[2:0]];
      end else begin
        last_data = 32'hdead_beef;
      end
    end
    if (!(accepted && fast)) begin
      exp.status.addr = last_addr;
      exp.status.data = last_data;
    end
    exp.status.status = dtm_pkg::dmi_resp_e'(e.exp_val[1:0]);
    if (!fast) begin
      run_idle(4);
    end
    // a nop scan whose capture shows the outcome
    shift_dr(dr_len, 64'd0, dout);
    run_idle(1);
    got = dout[dr_len-1:0];
    check_dmi(got, exp);
    sticky = e.exp_val[1:0];
  endtask

  task automatic run_entry(input entry_t e);
    logic [63:0] dout;
    case (e.kind)
      k_idcode: begin
        shift_dr(32, 64'd0, dout);
        run_idle(1);
        check_idcode(dout[31:0], e.exp_val);
      end
      k_bypass: begin
        shift_ir(ir_bypass);
        shift_dr(32, {32'd0, e.data}, dout);
        run_idle(1);
        check_bypass(dout[31:0], e.exp_val);
      end
      k_dtmcs_read, k_dtmcs_write: dtmcs_access(e);
      k_dmi_write, k_dmi_read, k_dmi_fast: dmi_access(e);
      default: begin
        tap_reset();
        sticky    = 2'd0;
        last_addr = '0;
        last_data = '0;
      end
    endcase
  endtask

  function automatic string kind_label(input kind_e k);
    case (k)
      k_idcode:      return "idcode";
      k_bypass:      return "bypass";
      k_dtmcs_read:  return "dtmcs read";
      k_dtmcs_write: return "dtmcs write";
      k_dmi_write:   return "dmi write";
      k_dmi_read:    return "dmi read";
      k_dmi_fast:    return "dmi fast read";
      default:       return "tap reset";
    endcase
  endfunction

  // --------------------
  // stimulus table
  // --------------------
  task automatic add_entry(input kind_e k, input int addr, input logic [31:0] data,
                           input logic [31:0] exp_val);
    entry_t e;
    e.kind    = k;
    e.addr    = addr[`DMI_ABITS-1:0];
    e.data    = data;
    e.exp_val = exp_val;
    stim_q.push_back(e);
  endtask

  task automatic build_table();
    logic [31:0] rnd;
    rnd = $random(seed);
    add_entry(k_idcode, 0, 32'd0, `DTM_IDCODE);
    // bypass delays td_i by one bit behind the captured zero
    add_entry(k_bypass, 0, rnd, {rnd[30:0], 1'b0});
    add_entry(k_dtmcs_read, 0, 32'd0, 32'd0);
    for (int a = 0; a < `DM_NUM_REGS; a++) begin
      rnd = $random(seed);
      add_entry(k_dmi_write, a, rnd, 32'd0);
    end
    for (int a = `DM_NUM_REGS - 1; a >= 0; a--) begin
      add_entry(k_dmi_read, a, 32'd0, 32'd0);
    end
    // an out of range read sets a sticky op failed error that blocks later scans
    add_entry(k_dmi_read, 9, 32'd0, 32'd2);
    add_entry(k_dtmcs_read, 0, 32'd0, 32'd2);
    rnd = $random(seed);
    add_entry(k_dmi_write, 2, rnd, 32'd2);
    add_entry(k_dtmcs_write, 0, 32'h0001_0000, 32'd2);
    add_entry(k_dtmcs_read, 0, 32'd0, 32'd0);
    add_entry(k_dmi_read, 2, 32'd0, 32'd0);
    // capture two edges after update hits a busy DTM
    add_entry(k_dmi_fast, 4, 32'd0, 32'd3);
    add_entry(k_dtmcs_read, 0, 32'd0, 32'd3);
    add_entry(k_dtmcs_write, 0, 32'h0001_0000, 32'd3);
    add_entry(k_dtmcs_read, 0, 32'd0, 32'd0);
    // test-logic-reset clears the error and the words survive
    add_entry(k_dmi_read, 12, 32'd0, 32'd2);
    add_entry(k_tap_reset, 0, 32'd0, 32'd0);
    add_entry(k_idcode, 0, 32'd0, `DTM_IDCODE);
    add_entry(k_dtmcs_read, 0, 32'd0, 32'd0);
    add_entry(k_dmi_read, 5, 32'd0, 32'd0);
  endtask

  // --------------------
  // main sequence
  // --------------------
  initial begin
    trst_ni   = 1'b0;
    tms_i     = 1'b1;
    td_i      = 1'b0;
    seed      = 28;
    sticky    = 2'd0;
    last_addr = '0;
    last_data = '0;
    for (int i = 0; i < `DM_NUM_REGS; i++) begin
      shadow[i] = '0;
    end
    build_table();
    table_built = 1'b1;
    repeat (5) @(posedge tck);
    @(negedge tck);
    trst_ni = 1'b1;
    // leave test-logic-reset
    run_idle(1);
    foreach (stim_q[i]) begin
      entry_ok = 1'b1;
      run_entry(stim_q[i]);
      if (entry_ok) begin
        pass_cnt++;
      end else begin
        fail_cnt++;
      end
      $display("test %0d %s addr %0d: %s", i, kind_label(stim_q[i].kind), stim_q[i].addr,
               entry_ok ? "passed" : "failed");
    end
    $display("%0d tests, %0d passed, %0d failed, %0d check errors",
             stim_q.size(), pass_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0 && fail_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // watchdog budget scales with the table length
  initial begin
    wait (table_built);
    repeat (stim_q.size() * 200) @(posedge tck);
    $display("run timed out after %0d tck cycles before the stimulus table completed",
             stim_q.size() * 200);
    $display("Finished with errors");
    $finish;
  end

endmodule

//--- sim.f
+incdir+include
rtl/dtm_pkg.sv
rtl/jtag_tap.sv
rtl/dmi_dtm.sv
rtl/dmi_req_fifo.sv
rtl/dm_regfile.sv
rtl/jtag_dmi_top.sv
tests/tb_jtag_dmi.sv

//--- Bender.yml
package:
  name: jtag_dmi

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/dtm_pkg.sv
      - rtl/jtag_tap.sv
      - rtl/dmi_dtm.sv
      - rtl/dmi_req_fifo.sv
      - rtl/dm_regfile.sv
      - rtl/jtag_dmi_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_jtag_dmi.sv
